//--- rtl/rv_isa_pkg.sv
/* rv32i instruction-set definitions
   field widths, major opcodes and the funct3 codes the core decodes */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] word_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // x0..x31
    typedef logic [6:0]  opcode_t;    // instr[6:0]
    typedef logic [2:0]  funct3_t;    // instr[14:12]

    // major opcodes
    localparam opcode_t OP_REG    = 7'b0110011;  // r-type alu
    localparam opcode_t OP_IMM    = 7'b0010011;  // i-type alu
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // alu funct3, shared by OP_REG and OP_IMM
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra by instr[30]
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branch funct3, bltu/bgeu not supported
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    // only full-word lw / sw
    localparam funct3_t F3_WORD = 3'b010;

endpackage

`default_nettype wire

//--- rtl/rv_ctrl_pkg.sv
/* internal control types of the core
   alu and write-back encodings plus the decode and execute bundles */
`default_nettype none

package rv_ctrl_pkg;

    // first ten codes match the original alu numbering
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10   // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_EQ     = 3'd1,
        BR_NE     = 3'd2,
        BR_LT     = 3'd3,    // signed
        BR_GE     = 3'd4,    // signed
        BR_ALWAYS = 3'd5     // jal
    } br_cond_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2        // jal link
    } wb_sel_e;

    typedef struct packed {
        rv_isa_pkg::reg_addr_t rd;
        rv_isa_pkg::reg_addr_t rs1;
        rv_isa_pkg::reg_addr_t rs2;
        alu_op_e               alu_op;
        logic                  use_imm;   // operand b from imm
        logic                  reg_we;
        logic                  mem_re;
        logic                  mem_we;
        br_cond_e              br_cond;
        wb_sel_e               wb_sel;
    } ctrl_t;

    typedef struct packed {
        rv_isa_pkg::word_t alu_result;
        rv_isa_pkg::word_t br_target;  // pc + imm
        logic              br_taken;
    } exec_t;

endpackage

`default_nettype wire

//--- rtl/rv_fetch.sv
/* program counter and run flag
   pc advances by 4 or jumps to the execute-stage target each cycle */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              br_taken,
    input  wire rv_isa_pkg::word_t br_target,
    output rv_isa_pkg::word_t      pc,
    output logic                   run
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc  <= RESET_PC;
            run <= 1'b0;
        end else begin
            run <= 1'b1;              // set on first edge after reset
            if (run) begin            // hold pc until running, first instr sits at RESET_PC
                pc <= br_taken ? br_target : pc + 32'd4;
            end
        end
    end

    // word alignment, no misaligned handling in the core
    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);
    a_target_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        (run && br_taken) |-> (br_target[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/rv_decoder.sv
/* instruction decoder
   maps an rv32i word onto control fields and a sign-extended immediate */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  wire rv_isa_pkg::word_t instr,
    input  wire logic              run,
    output rv_ctrl_pkg::ctrl_t     ctrl,
    output rv_isa_pkg::word_t      imm
);

    rv_isa_pkg::opcode_t opcode;
    rv_isa_pkg::funct3_t funct3;
    rv_isa_pkg::word_t   imm_i;
    rv_isa_pkg::word_t   imm_s;
    rv_isa_pkg::word_t   imm_b;
    rv_isa_pkg::word_t   imm_u;
    rv_isa_pkg::word_t   imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // immediate formats, all sign-extended from instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // alu op from funct3; alt_sub only honoured for r-type add
    function automatic rv_ctrl_pkg::alu_op_e alu_sel(input rv_isa_pkg::funct3_t f3,
                                                     input logic alt_sub,
                                                     input logic alt_sra);
        case (f3)
            rv_isa_pkg::F3_ADD:  alu_sel = alt_sub ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  alu_sel = rv_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  alu_sel = rv_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: alu_sel = rv_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  alu_sel = rv_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   alu_sel = alt_sra ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   alu_sel = rv_ctrl_pkg::ALU_OR;
            default:             alu_sel = rv_ctrl_pkg::ALU_AND;  // F3_AND
        endcase
    endfunction

    always_comb begin
        ctrl         = '0;                      // nop unless matched below
        ctrl.rd      = instr[11:7];
        ctrl.rs1     = instr[19:15];
        ctrl.rs2     = instr[24:20];
        ctrl.alu_op  = rv_ctrl_pkg::ALU_ADD;
        ctrl.br_cond = rv_ctrl_pkg::BR_NONE;
        ctrl.wb_sel  = rv_ctrl_pkg::WB_ALU;
        imm          = imm_i;

        case (opcode)
            rv_isa_pkg::OP_REG: begin
                ctrl.alu_op = alu_sel(funct3, instr[30], instr[30]);
                ctrl.reg_we = 1'b1;
            end
            rv_isa_pkg::OP_IMM: begin
                ctrl.alu_op  = alu_sel(funct3, 1'b0, instr[30]);  // addi has no sub form
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            rv_isa_pkg::OP_LUI: begin
                imm          = imm_u;
                ctrl.alu_op  = rv_ctrl_pkg::ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            rv_isa_pkg::OP_LOAD: begin
                ctrl.use_imm = 1'b1;                       // rs1 + imm_i
                ctrl.reg_we  = (funct3 == rv_isa_pkg::F3_WORD);
                ctrl.mem_re  = (funct3 == rv_isa_pkg::F3_WORD);
                ctrl.wb_sel  = rv_ctrl_pkg::WB_MEM;
            end
            rv_isa_pkg::OP_STORE: begin
                imm          = imm_s;
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = (funct3 == rv_isa_pkg::F3_WORD);  // sb/sh dropped
            end
            rv_isa_pkg::OP_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    rv_isa_pkg::F3_BEQ: ctrl.br_cond = rv_ctrl_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE: ctrl.br_cond = rv_ctrl_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT: ctrl.br_cond = rv_ctrl_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE: ctrl.br_cond = rv_ctrl_pkg::BR_GE;
                    default:            ctrl.br_cond = rv_ctrl_pkg::BR_NONE;
                endcase
            end
            rv_isa_pkg::OP_JAL: begin
                imm          = imm_j;
                ctrl.reg_we  = 1'b1;
                ctrl.br_cond = rv_ctrl_pkg::BR_ALWAYS;
                ctrl.wb_sel  = rv_ctrl_pkg::WB_PC4;     // link = pc + 4
            end
            default: ;                                  // unsupported, stays nop
        endcase

        // squash side effects until fetch is running
        if (!run) begin
            ctrl.reg_we  = 1'b0;
            ctrl.mem_re  = 1'b0;
            ctrl.mem_we  = 1'b0;
            ctrl.br_cond = rv_ctrl_pkg::BR_NONE;
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
/* integer register file, x0 hardwired to zero
   two async read ports and one write port on the rising edge */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rv_isa_pkg::reg_addr_t rs1,
    input  wire rv_isa_pkg::reg_addr_t rs2,
    output rv_isa_pkg::word_t          rs1_data,
    output rv_isa_pkg::word_t          rs2_data,
    input  wire logic                  we,
    input  wire rv_isa_pkg::reg_addr_t rd,
    input  wire rv_isa_pkg::word_t     wdata
);

    rv_isa_pkg::word_t regs [32];
    logic              wr_en;

    assign wr_en = we && (rd != '0);  // x0 writes dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads, regs[0] stays zero
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- rtl/rv_execute.sv
/* execute stage
   alu, branch compare on rs1/rs2 and the pc-relative target adder */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire rv_ctrl_pkg::ctrl_t ctrl,
    input  wire rv_isa_pkg::word_t  rs1_data,
    input  wire rv_isa_pkg::word_t  rs2_data,
    input  wire rv_isa_pkg::word_t  imm,
    input  wire rv_isa_pkg::word_t  pc,
    output rv_ctrl_pkg::exec_t      ex
);

    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_y;
    logic              eq;
    logic              lt;
    logic              taken;

    assign op_b = ctrl.use_imm ? imm : rs2_data;

    always_comb begin
        case (ctrl.alu_op)
            rv_ctrl_pkg::ALU_ADD:    alu_y = rs1_data + op_b;
            rv_ctrl_pkg::ALU_SUB:    alu_y = rs1_data - op_b;
            rv_ctrl_pkg::ALU_AND:    alu_y = rs1_data & op_b;
            rv_ctrl_pkg::ALU_OR:     alu_y = rs1_data | op_b;
            rv_ctrl_pkg::ALU_XOR:    alu_y = rs1_data ^ op_b;
            rv_ctrl_pkg::ALU_SLL:    alu_y = rs1_data << op_b[4:0];
            rv_ctrl_pkg::ALU_SRL:    alu_y = rs1_data >> op_b[4:0];
            rv_ctrl_pkg::ALU_SRA:    alu_y = $signed(rs1_data) >>> op_b[4:0];
            rv_ctrl_pkg::ALU_SLT:    alu_y = {31'b0, $signed(rs1_data) < $signed(op_b)};
            rv_ctrl_pkg::ALU_SLTU:   alu_y = {31'b0, rs1_data < op_b};  // unsigned
            rv_ctrl_pkg::ALU_PASS_B: alu_y = op_b;                      // lui
            default:                 alu_y = '0;
        endcase
    end

    // branches always compare the two registers, never the imm
    assign eq = (rs1_data == rs2_data);
    assign lt = ($signed(rs1_data) < $signed(rs2_data));

    always_comb begin
        case (ctrl.br_cond)
            rv_ctrl_pkg::BR_EQ:     taken = eq;
            rv_ctrl_pkg::BR_NE:     taken = !eq;
            rv_ctrl_pkg::BR_LT:     taken = lt;
            rv_ctrl_pkg::BR_GE:     taken = !lt;
            rv_ctrl_pkg::BR_ALWAYS: taken = 1'b1;  // jal
            default:                taken = 1'b0;
        endcase
    end

    assign ex.alu_result = alu_y;
    assign ex.br_target  = pc + imm;  // b and j offsets
    assign ex.br_taken   = taken;

endmodule

`default_nettype wire

//--- rtl/rv_result.sv
/* result stage
   drives the data-memory port and picks the register write-back value */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  wire rv_ctrl_pkg::ctrl_t ctrl,
    input  wire rv_ctrl_pkg::exec_t ex,
    input  wire rv_isa_pkg::word_t  rs2_data,
    input  wire rv_isa_pkg::word_t  pc,
    output rv_isa_pkg::word_t       dmem_addr,
    output rv_isa_pkg::word_t       dmem_wdata,
    output logic                    dmem_we,
    output logic                    dmem_re,
    input  wire rv_isa_pkg::word_t  dmem_rdata,
    output logic                    reg_we,
    output rv_isa_pkg::word_t       wb_data
);

    assign dmem_addr  = ex.alu_result;  // rs1 + offset
    assign dmem_wdata = rs2_data;
    assign dmem_we    = ctrl.mem_we;
    assign dmem_re    = ctrl.mem_re;
    assign reg_we     = ctrl.reg_we;

    always_comb begin
        case (ctrl.wb_sel)
            rv_ctrl_pkg::WB_MEM: wb_data = dmem_rdata;  // zero-wait read
            rv_ctrl_pkg::WB_PC4: wb_data = pc + 32'd4;
            default:             wb_data = ex.alu_result;
        endcase
    end

    // decode must never emit load and store on the same instruction
    always_comb begin
        a_mem_excl : assert (!(ctrl.mem_we && ctrl.mem_re))
            else $error("data port read and write in one cycle");
    end

endmodule

`default_nettype wire

//--- rtl/rv_core_top.sv
/* single-cycle rv32i core
   fetch, decode, register file, execute and result joined to the memory ports */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    output rv_isa_pkg::word_t      instr_addr,
    input  wire rv_isa_pkg::word_t instr_data,
    output rv_isa_pkg::word_t      dmem_addr,
    output rv_isa_pkg::word_t      dmem_wdata,
    output logic                   dmem_we,
    output logic                   dmem_re,
    input  wire rv_isa_pkg::word_t dmem_rdata
);

    rv_isa_pkg::word_t  pc;
    logic               run;
    rv_ctrl_pkg::ctrl_t ctrl;
    rv_isa_pkg::word_t  imm;
    rv_isa_pkg::word_t  rs1_data;
    rv_isa_pkg::word_t  rs2_data;
    rv_ctrl_pkg::exec_t ex;
    logic               reg_we;
    rv_isa_pkg::word_t  wb_data;

    assign instr_addr = pc;  // imem is combinational

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) rv_fetch_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .br_taken (ex.br_taken),
        .br_target(ex.br_target),
        .pc       (pc),
        .run      (run)
    );

    rv_decoder rv_decoder_inst (
        .instr(instr_data),
        .run  (run),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_regfile rv_regfile_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .we      (reg_we),
        .rd      (ctrl.rd),
        .wdata   (wb_data)
    );

    rv_execute rv_execute_inst (
        .ctrl    (ctrl),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .imm     (imm),
        .pc      (pc),
        .ex      (ex)
    );

    rv_result rv_result_inst (
        .ctrl      (ctrl),
        .ex        (ex),
        .rs2_data  (rs2_data),
        .pc        (pc),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we   (dmem_we),
        .dmem_re   (dmem_re),
        .dmem_rdata(dmem_rdata),
        .reg_we    (reg_we),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
/* testbench clock and reset source
   100 ns clock, active-low reset held over the first rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,  // ns
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;  // release just after the edge
    end

endmodule

`default_nettype wire

//--- test/rv_core_tb.sv
/* testbench for the single-cycle rv32i core
   imem/dmem models, a generated program and store-by-store checking */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam rv_isa_pkg::word_t RESET_PC = 32'h0000_0100;
    localparam rv_isa_pkg::word_t NOP      = 32'h0000_0013;  // addi x0, x0, 0
    localparam int unsigned SEED           = 32'h47e6_95c0;
    localparam int STORE_TIMEOUT           = 20;             // cycles per store
    localparam int RESET_TIMEOUT           = 10;
    localparam int POISON_ADDR             = 'hfc;           // must never be written

    typedef enum logic [3:0] {
        REF_ADD, REF_SUB, REF_AND, REF_OR, REF_XOR,
        REF_SLL, REF_SRL, REF_SRA, REF_SLT, REF_SLTU,
        REF_PASS  // result is operand a
    } ref_op_e;

    // one expected store
    typedef struct packed {
        rv_isa_pkg::word_t addr;
        ref_op_e           op;
        rv_isa_pkg::word_t a;
        rv_isa_pkg::word_t b;
    } store_row_t;

    logic              clk;
    logic              rst_n;
    rv_isa_pkg::word_t instr_addr;
    rv_isa_pkg::word_t instr_data;
    rv_isa_pkg::word_t dmem_addr;
    rv_isa_pkg::word_t dmem_wdata;
    rv_isa_pkg::word_t dmem_rdata;
    logic              dmem_we;
    logic              dmem_re;

    rv_isa_pkg::word_t imem [128];
    rv_isa_pkg::word_t dmem [64];
    rv_isa_pkg::word_t imem_off;
    rv_isa_pkg::word_t rnd [4];     // random operands, dmem words 0..3
    rv_isa_pkg::word_t prog [$];    // program table
    store_row_t        exp_q [$];   // expected stores in order
    int                st_addr;     // next result slot

    tb_clock_gen tb_clock_gen_inst (
        .clk  (clk),
        .rst_n(rst_n)
    );

    rv_core_top #(
        .RESET_PC(RESET_PC)
    ) rv_core_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .instr_addr(instr_addr),
        .instr_data(instr_data),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we   (dmem_we),
        .dmem_re   (dmem_re),
        .dmem_rdata(dmem_rdata)
    );

    // zero-wait memories
    assign imem_off   = instr_addr - RESET_PC;
    assign instr_data = imem[imem_off[8:2]];
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : '0;  // data only on a read

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;  // write at the end of the store cycle
        end
    end

    // instruction encoders, field layout per the rv32i spec
    function automatic rv_isa_pkg::word_t enc_r(input int f7, input int f3, input int rd,
                                                input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_i(input int imm, input int rs1, input int f3,
                                                input int rd, input int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic rv_isa_pkg::word_t enc_s(input int imm, input int rs2, input int rs1,
                                                input int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_b(input int imm, input int rs2, input int rs1,
                                                input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic rv_isa_pkg::word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic rv_isa_pkg::word_t enc_u(input int imm20, input int rd);
        return {imm20[19:0], rd[4:0], 7'b0110111};  // lui
    endfunction

    function automatic rv_isa_pkg::word_t sext12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    // expected result from the isa definition of each operation
    function automatic rv_isa_pkg::word_t ref_result(input ref_op_e op,
                                                     input rv_isa_pkg::word_t a,
                                                     input rv_isa_pkg::word_t b);
        logic [4:0] sh;
        sh = b[4:0];  // shifts use the low five bits
        case (op)
            REF_ADD:  return a + b;
            REF_SUB:  return a - b;
            REF_AND:  return a & b;
            REF_OR:   return a | b;
            REF_XOR:  return a ^ b;
            REF_SLL:  return a << sh;
            REF_SRL:  return a >> sh;
            REF_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            REF_SLT:  return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};  // sign decides first
            REF_SLTU: return {31'b0, a < b};
            default:  return a;
        endcase
    endfunction

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string what, input rv_isa_pkg::word_t act,
                         input rv_isa_pkg::word_t exp);
        if (act !== exp) begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, act, exp);
            abort_run();
        end
    endtask

    // sw rs2, st_addr(x0) plus its table row
    task automatic store_expect(input int rs2, input ref_op_e op, input rv_isa_pkg::word_t a,
                                input rv_isa_pkg::word_t b);
        store_row_t row;
        prog.push_back(enc_s(st_addr, rs2, 0, 2));
        row.addr = rv_isa_pkg::word_t'(st_addr);
        row.op   = op;
        row.a    = a;
        row.b    = b;
        exp_q.push_back(row);
        st_addr += 4;
    endtask

    task automatic poison();
        prog.push_back(enc_s(POISON_ADDR, 1, 0, 2));  // only reached if a jump fails
    endtask

    task automatic r_case(input int f7, input int f3, input ref_op_e op);
        prog.push_back(enc_r(f7, f3, 5, 1, 2));  // x5 = x1 op x2
        store_expect(5, op, rnd[0], rnd[1]);
    endtask

    task automatic i_case(input int f3, input int imm, input ref_op_e op);
        prog.push_back(enc_i(imm, 3, f3, 5, 'h13));  // x5 = x3 op imm
        store_expect(5, op, rnd[2], sext12(imm));
    endtask

    task automatic build_program();
        rv_isa_pkg::word_t flip;
        rv_isa_pkg::word_t link;
        flip    = rnd[0] ^ 32'h8000_0000;  // x6, opposite sign of x1
        st_addr = 'h40;
        prog.push_back(enc_i(0, 0, 2, 1, 'h03));   // lw x1..x4
        prog.push_back(enc_i(4, 0, 2, 2, 'h03));
        prog.push_back(enc_i(8, 0, 2, 3, 'h03));
        prog.push_back(enc_i(12, 0, 2, 4, 'h03));
        store_expect(1, REF_PASS, rnd[0], '0);     // load written back
        store_expect(2, REF_PASS, rnd[1], '0);
        r_case(0, 0, REF_ADD);
        r_case('h20, 0, REF_SUB);
        r_case(0, 7, REF_AND);
        r_case(0, 6, REF_OR);
        r_case(0, 4, REF_XOR);
        r_case(0, 1, REF_SLL);
        r_case(0, 5, REF_SRL);
        r_case('h20, 5, REF_SRA);
        r_case(0, 2, REF_SLT);
        r_case(0, 3, REF_SLTU);
        prog.push_back(enc_u('h80000, 7));         // lui x7
        store_expect(7, REF_PASS, 32'h8000_0000, '0);
        prog.push_back(enc_r(0, 4, 6, 1, 7));      // xor x6, x1, x7
        prog.push_back(enc_r(0, 2, 5, 1, 6));      // signed and unsigned disagree here
        store_expect(5, REF_SLT, rnd[0], flip);
        prog.push_back(enc_r(0, 3, 5, 1, 6));
        store_expect(5, REF_SLTU, rnd[0], flip);
        i_case(0, -1234, REF_ADD);
        i_case(7, 'h0ff, REF_AND);
        i_case(6, -256, REF_OR);
        i_case(4, 'h555, REF_XOR);
        i_case(2, -5, REF_SLT);
        i_case(3, -5, REF_SLTU);
        i_case(1, 7, REF_SLL);
        i_case(5, 9, REF_SRL);
        i_case(5, 'h40d, REF_SRA);                 // srai 13
        prog.push_back(enc_i('h123, 1, 0, 0, 'h13));  // write to x0 dropped
        store_expect(0, REF_PASS, '0, '0);
        prog.push_back(enc_b(8, 1, 1, 0));         // beq taken
        poison();
        store_expect(2, REF_PASS, rnd[1], '0);
        prog.push_back(enc_b(8, 6, 1, 1));         // bne taken
        poison();
        store_expect(3, REF_PASS, rnd[2], '0);
        link = RESET_PC + rv_isa_pkg::word_t'(4 * prog.size() + 4);
        prog.push_back(enc_j(8, 9));               // jal x9
        poison();
        store_expect(9, REF_PASS, link, '0);
        prog.push_back(enc_b(8, 1, 1, 4));         // blt x1, x1 falls through
        store_expect(4, REF_PASS, rnd[3], '0);
        prog.push_back(enc_b(8, 0, 7, 5));         // bge min_int, x0 falls through
        store_expect(1, REF_PASS, rnd[0], '0);
        prog.push_back(enc_j(0, 0));               // park
    endtask

    task automatic wait_store(input int idx, input rv_isa_pkg::word_t addr);
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);  // mid-cycle, outputs settled
            cyc++;
        end while (!dmem_we && cyc < STORE_TIMEOUT);
        if (!dmem_we) begin
            $display("store %0d to address %h never came", idx, addr);
            abort_run();
        end
    endtask

    initial begin
        store_row_t row;
        int         cyc;
        void'($urandom(SEED));
        for (int i = 0; i < 4; i++) begin
            rnd[i] = $urandom();
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] <= (i < 4) ? rnd[i] : '0;
        end
        build_program();
        for (int i = 0; i < 128; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP;
        end

        // pc parked and data port idle while in reset
        cyc = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                check("pc in reset", instr_addr, RESET_PC);
                check("dmem_we in reset", 32'(dmem_we), '0);
                check("dmem_re in reset", 32'(dmem_re), '0);
            end
            cyc++;
            if (cyc > RESET_TIMEOUT) begin
                $display("reset was never released");
                abort_run();
            end
        end
        check("pc after reset", instr_addr, RESET_PC);  // run flag still low
        check("dmem_we after reset", 32'(dmem_we), '0);

        for (int r = 0; r < exp_q.size(); r++) begin
            row = exp_q[r];
            wait_store(r, row.addr);
            check($sformatf("store %0d address", r), dmem_addr, row.addr);
            check($sformatf("store %0d data", r), dmem_wdata,
                  ref_result(row.op, row.a, row.b));
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core_top.sv
test/tb_clock_gen.sv
test/rv_core_tb.sv

//--- Makefile
# Verilator build and run of the rv32i core testbench
TOP := rv_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f

# exit status of the simulation is the test result
run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir
